// ==== rtl/ula_defines.svh ====
`ifndef ULA_DEFINES_SVH
`define ULA_DEFINES_SVH

////////////////////////////////////////
// Sequencer
////////////////////////////////////////
`define SEQ_STATES      24          // 24 MHz clocks per CPU cycle

////////////////////////////////////////
// Video timing, in PHI2 clocks and lines
////////////////////////////////////////
`define H_TOTAL         64          // Clocks per line
`define H_SYNC_START    49
`define H_SYNC_END      53          // Last low clock of HSYNC
`define H_ACTIVE_END    40          // Last visible column, first is 1
`define TEXT_COLS       40          // Characters per text row

`define V_LAST_50       312         // 313 lines per frame
`define V_LAST_60       260         // 261 lines per frame
`define VSYNC50_START   258
`define VSYNC60_START   241
`define VSYNC_LINES     2
`define V_BLANK_START   224

////////////////////////////////////////
// Memory map
////////////////////////////////////////
`define TEXT_BASE       16'hBB80    // Text screen
`define CHARSET_STD     6'b101101   // Standard set at 0xB400
`define CHARSET_ALT     6'b101110   // Alternate set at 0xB800
`define IO_PAGE         8'h03       // 0x0300 to 0x03FF
`define ROM_PREFIX      2'b11       // 0xC000 upward

`endif

// ==== rtl/ula_bus_pkg.sv ====
`default_nettype none

package ula_bus_pkg;

  // CPU and SRAM address
  typedef logic [15:0] cpuAddrT;

  // Data bus byte
  typedef logic [7:0] dataByteT;

  // Chip selects, all active low
  typedef struct packed {
    logic ioN;    // Page 3 I/O
    logic romN;   // ROM from 0xC000
    logic ramN;   // Normal and shadow RAM
  } chipSelT;

  // SRAM strobes
  typedef struct packed {
    logic oe;     // Output enable, high on reads
    logic ce;     // Chip enable
    logic we;     // Write pulse, one clock
    logic latch;  // Data latch strobe
  } sramCtrlT;

endpackage

`default_nettype wire

// ==== rtl/ula_video_pkg.sv ====
`default_nettype none

`include "ula_defines.svh"

package ula_video_pkg;

  typedef logic [`SEQ_STATES-1:0] seqStateT;  // One-hot ring
  typedef logic [2:0]             phaseT;     // One-hot phase
  typedef logic [6:0]             hCountT;    // Clocks in a line
  typedef logic [8:0]             vCountT;    // Lines in a frame
  typedef logic [2:0]             rgbT;       // Bit 0 red, bit 2 blue

  // Attribute register selected by byte bits 6 to 3
  typedef enum logic [3:0] {
    INK   = 4'h0,
    STYLE = 4'h1,
    PAPER = 4'h2,
    MODE  = 4'h3
  } attrRegE;

  // Timing bundle shared by the video blocks
  typedef struct packed {
    hCountT hCount;
    vCountT vCount;
    logic   hBlank;      // Outside columns 1 to 40
    logic   vBlank;      // Bottom border and retrace
    logic   reloadZone;  // End of line, attributes back to defaults
    logic   flashClk;    // Toggles every 16 frames
  } vidTimingT;

endpackage

`default_nettype wire

// ==== rtl/ula_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ula_defines.svh"

module ula_sequencer
  import ula_video_pkg::*;
(
  input  wire  CLK_24,
  input  wire  RESET_INT,
  output seqStateT state,     // One-hot, 24 states
  output phaseT    phase,     // Video 1, video 2, CPU
  output logic     PHI2,      // 1 MHz CPU clock
  output logic     PHI2_EN    // One clock per CPU cycle
);

  logic phaseStep;  // End of an 8 clock phase

  assign phaseStep = state[7] | state[15] | state[`SEQ_STATES-1];

  ////////////////////////////////////////
  // State and phase rings
  ////////////////////////////////////////
  always_ff @(posedge CLK_24, posedge RESET_INT) begin
    if (RESET_INT) begin
      state <= seqStateT'(1);
      phase <= 3'b001;
    end else begin
      state <= {state[`SEQ_STATES-2:0], state[`SEQ_STATES-1]};  // Rotate left
      if (phaseStep) begin
        phase <= {phase[1:0], phase[2]};
      end
    end
  end

  // CPU owns the bus in phase 3
  assign PHI2    = phase[2];
  assign PHI2_EN = state[15];  // Last state of phase 2

endmodule

`default_nettype wire

// ==== rtl/ula_video_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ula_defines.svh"

module ula_video_timing
  import ula_video_pkg::*;
(
  input  wire       CLK_24,
  input  wire       RESET_INT,
  input  wire       PHI2_EN,
  input  wire       freq50,   // Mode register, 1 selects 50 Hz
  output vidTimingT timing,
  output logic      HSYNC,    // Active low
  output logic      VSYNC,    // Active low
  output logic      SYNC      // Composite
);

  hCountT     hCnt;
  vCountT     vCnt;
  vCountT     lastLine;
  vCountT     vsyncStart;
  logic [4:0] flashCnt;     // Frame counter for flashing
  logic       lineEnd;

  assign lineEnd    = (hCnt == hCountT'(`H_TOTAL - 1));
  assign lastLine   = freq50 ? vCountT'(`V_LAST_50) : vCountT'(`V_LAST_60);
  assign vsyncStart = freq50 ? vCountT'(`VSYNC50_START) : vCountT'(`VSYNC60_START);

  ////////////////////////////////////////
  // Line, frame and flash counters
  ////////////////////////////////////////
  always_ff @(posedge CLK_24, posedge RESET_INT) begin
    if (RESET_INT) begin
      hCnt     <= '0;
      vCnt     <= '0;
      flashCnt <= '0;
    end else if (PHI2_EN) begin
      hCnt <= lineEnd ? '0 : hCnt + 1'b1;
      if (lineEnd) begin
        if (vCnt >= lastLine) begin  // Also catches a 50 to 60 Hz switch late in frame
          vCnt     <= '0;
          flashCnt <= flashCnt + 1'b1;
        end else begin
          vCnt <= vCnt + 1'b1;
        end
      end
    end
  end

  // Sync pulses
  assign HSYNC = ~((hCnt >= `H_SYNC_START) && (hCnt <= `H_SYNC_END));
  assign VSYNC = ~((vCnt >= vsyncStart) && (vCnt < vsyncStart + `VSYNC_LINES));
  assign SYNC  = ~(HSYNC ^ VSYNC);  // Inverted during VSYNC

  assign timing.hCount     = hCnt;
  assign timing.vCount     = vCnt;
  assign timing.hBlank     = (hCnt == '0) || (hCnt > `H_ACTIVE_END);
  assign timing.vBlank     = (vCnt >= `V_BLANK_START);
  assign timing.reloadZone = (hCnt >= `H_SYNC_START);
  assign timing.flashClk   = flashCnt[4];

endmodule

`default_nettype wire

// ==== rtl/ula_attribute_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module ula_attribute_decoder
  import ula_bus_pkg::*;
  import ula_video_pkg::*;
(
  input  wire       CLK_24,
  input  wire       RESET_INT,
  input  seqStateT  state,
  input  dataByteT  DB,
  input  vidTimingT timing,
  output dataByteT  charCode,    // Phase 1 byte, feeds the charset address
  output logic      altCharset,
  output logic      freq50,
  output rgbT       rgb,
  output logic      CLK_PIX,     // Six pulses per cycle
  output logic      HBLANK,
  output logic      VBLANK
);

  dataByteT   patternByte;  // Phase 2 byte
  logic [6:0] holdReg;
  logic [5:0] shifter;
  logic       isAttrib;
  logic       invHold;
  logic       inv;
  logic [2:0] ink, style, paper, mode;
  logic       pixEn;
  logic       fgSel;
  rgbT        colour;

  assign pixEn = state[1] | state[5] | state[9] | state[13] | state[17] | state[21];

  // Bytes off the SRAM
  always_ff @(posedge CLK_24) begin
    if (state[2]) charCode <= DB;      // Screen byte
    if (state[10]) patternByte <= DB;  // Charset row
    if (state[12]) begin
      holdReg <= isAttrib ? charCode[6:0] : patternByte[6:0];
    end
  end

  always_ff @(posedge CLK_24, posedge RESET_INT) begin
    if (RESET_INT) begin
      isAttrib <= 1'b0;
      invHold  <= 1'b0;
      inv      <= 1'b0;
    end else begin
      if (state[3]) begin
        isAttrib <= ~(|DB[6:5]);  // Bits 6,5 zero means attribute
        invHold  <= DB[7];
      end
      if (state[17]) inv <= invHold;  // In step with the shifter load
    end
  end

  ////////////////////////////////////////
  // Attribute registers
  ////////////////////////////////////////
  always_ff @(posedge CLK_24, posedge RESET_INT) begin
    if (RESET_INT) begin
      ink   <= 3'd7;
      style <= '0;
      paper <= '0;
      mode  <= '0;
    end else if (timing.reloadZone) begin
      ink   <= 3'd7;  // White on black each line
      style <= '0;
      paper <= '0;
    end else if (state[17] && isAttrib && !(timing.hBlank || timing.vBlank)) begin
      case (attrRegE'(holdReg[6:3]))
        INK:     ink   <= holdReg[2:0];
        STYLE:   style <= holdReg[2:0];
        PAPER:   paper <= holdReg[2:0];
        MODE:    mode  <= holdReg[2:0];
        default: ;  // Not a register
      endcase
    end
  end

  assign altCharset = style[0];
  assign freq50     = mode[1];

  // Pixel shifter, MSB out first
  always_ff @(posedge CLK_24) begin
    if (pixEn) begin
      if (state[17]) shifter <= isAttrib ? 6'd0 : holdReg[5:0];  // Attribute cell is paper
      else           shifter <= {shifter[4:0], 1'b0};
    end
  end

  assign fgSel  = (timing.flashClk && style[2]) ? 1'b0 : shifter[5];  // Flash blanks ink
  assign colour = fgSel ? ink : paper;
  assign rgb    = inv ? ~colour : colour;

  // Blanking in step with pixels
  always_ff @(posedge CLK_24, posedge RESET_INT) begin
    if (RESET_INT) begin
      HBLANK <= 1'b1;
      VBLANK <= 1'b1;
    end else if (pixEn) begin
      HBLANK <= timing.hBlank;
      VBLANK <= timing.vBlank;
    end
  end

  assign CLK_PIX = pixEn;

endmodule

`default_nettype wire

// ==== rtl/ula_memory_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ula_defines.svh"

module ula_memory_controller
  import ula_bus_pkg::*;
  import ula_video_pkg::*;
(
  input  wire       CLK_24,
  input  seqStateT  state,
  input  phaseT     phase,
  input  vidTimingT timing,
  input  dataByteT  charCode,
  input  wire       altCharset,
  input  cpuAddrT   ADDR,
  input  wire       RW,         // High reads
  input  wire       MAPn,       // Low maps RAM over ROM
  output cpuAddrT   SRAM_AD,
  output chipSelT   selects,
  output sramCtrlT  sramCtrl
);

  logic       phi2;
  logic       ioHit;
  logic       romArea;
  logic [5:0] charRow;      // Text row, 8 lines each
  logic [5:0] charsetHi;
  cpuAddrT    rowOffset;
  cpuAddrT    vidAddr1;     // Screen byte
  cpuAddrT    vidAddr2;     // Charset row

  assign phi2 = phase[2];

  ////////////////////////////////////////
  // CPU decode
  ////////////////////////////////////////
  assign ioHit   = (ADDR[15:8] == `IO_PAGE);
  assign romArea = (ADDR[15:14] == `ROM_PREFIX);

  assign selects.ioN  = ~(ioHit & phi2);
  assign selects.romN = ~(romArea & MAPn & phi2);
  assign selects.ramN = ~(phi2 & ~ioHit & ~(romArea & MAPn));  // Shadow RAM when MAPn low

  // Video addresses
  assign charRow   = timing.vCount[8:3];
  assign rowOffset = {5'd0, charRow, 5'd0} + {7'd0, charRow, 3'd0};  // Row times 40
  assign vidAddr1  = `TEXT_BASE + rowOffset + {9'd0, timing.hCount};
  assign charsetHi = altCharset ? `CHARSET_ALT : `CHARSET_STD;
  assign vidAddr2  = {charsetHi, charCode[6:0], timing.vCount[2:0]};

  // Address for the coming phase
  always_ff @(posedge CLK_24) begin
    if (state[23])      SRAM_AD <= vidAddr1;
    else if (state[7])  SRAM_AD <= vidAddr2;
    else if (state[15]) SRAM_AD <= ADDR;
  end

  ////////////////////////////////////////
  // SRAM strobes
  ////////////////////////////////////////
  //                   video 1    video 2
  assign sramCtrl.oe = phase[0] | phase[1] | RW;
  assign sramCtrl.ce = phase[0] | phase[1] | (phase[2] & ~selects.ramN);
  assign sramCtrl.we = ~selects.ramN & ~RW & state[17];   // Mid phase 3
  assign sramCtrl.latch = ~state[4] & ~state[12] & ~state[20];

endmodule

`default_nettype wire

// ==== rtl/ula_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ula_top
  import ula_bus_pkg::*;
  import ula_video_pkg::*;
(
  input  wire      CLK_24,
  input  wire      RESET_INT,
  input  wire      RW,
  input  wire      MAPn,
  input  dataByteT DB,
  input  cpuAddrT  ADDR,
  output logic     PHI2,
  output logic     PHI2_EN,
  output logic     CSIOn,
  output logic     CSROMn,
  output logic     CSRAMn,
  output cpuAddrT  SRAM_AD,
  output logic     SRAM_OE,
  output logic     SRAM_CE,
  output logic     SRAM_WE,
  output logic     LATCH_SRAM,
  output logic     R,
  output logic     G,
  output logic     B,
  output logic     SYNC,
  output logic     HSYNC,
  output logic     VSYNC,
  output logic     CLK_PIX,
  output logic     HBLANK,
  output logic     VBLANK
);

  seqStateT  state;
  phaseT     phase;
  vidTimingT timing;
  dataByteT  charCode;
  logic      altCharset;
  logic      freq50;      // From the mode register
  rgbT       rgb;
  chipSelT   selects;
  sramCtrlT  sramCtrl;

  ula_sequencer uSeq (
    .CLK_24, .RESET_INT, .state, .phase, .PHI2, .PHI2_EN
  );

  ula_video_timing uTiming (
    .CLK_24, .RESET_INT, .PHI2_EN, .freq50, .timing, .HSYNC, .VSYNC, .SYNC
  );

  ula_attribute_decoder uAttr (
    .CLK_24, .RESET_INT, .state, .DB, .timing, .charCode, .altCharset,
    .freq50, .rgb, .CLK_PIX, .HBLANK, .VBLANK
  );

  ula_memory_controller uMem (
    .CLK_24, .state, .phase, .timing, .charCode, .altCharset,
    .ADDR, .RW, .MAPn, .SRAM_AD, .selects, .sramCtrl
  );

  // Pins
  assign CSIOn      = selects.ioN;
  assign CSROMn     = selects.romN;
  assign CSRAMn     = selects.ramN;
  assign SRAM_OE    = sramCtrl.oe;
  assign SRAM_CE    = sramCtrl.ce;
  assign SRAM_WE    = sramCtrl.we;
  assign LATCH_SRAM = sramCtrl.latch;
  assign R          = rgb[0];
  assign G          = rgb[1];
  assign B          = rgb[2];

endmodule

`default_nettype wire

// ==== verification/ula_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ula_defines.svh"

module ulaAssert
  import ula_video_pkg::*;
(
  input wire      CLK_24,
  input wire      RESET_INT,
  input seqStateT state,
  input wire      PHI2,
  input wire      PHI2_EN,
  input wire      SRAM_WE
);

  int failCount = 0;  // Read by the testbench

  stateOneHot: assert property (@(posedge CLK_24) disable iff (RESET_INT) $onehot(state))
    else begin
      $error("Sequencer state is not one-hot");
      failCount++;
    end

  // One enable per 24 clocks
  phi2EnPeriod: assert property (@(posedge CLK_24) disable iff (RESET_INT)
    PHI2_EN |=> (!PHI2_EN [*(`SEQ_STATES - 1)]) ##1 PHI2_EN)
    else begin
      $error("PHI2_EN is not periodic");
      failCount++;
    end

  weInPhi2: assert property (@(posedge CLK_24) disable iff (RESET_INT) SRAM_WE |-> PHI2)
    else begin
      $error("SRAM_WE outside PHI2");
      failCount++;
    end

endmodule

bind ula_top ulaAssert uAssert (
  .CLK_24(CLK_24), .RESET_INT(RESET_INT), .state(state),
  .PHI2(PHI2), .PHI2_EN(PHI2_EN), .SRAM_WE(SRAM_WE)
);

`default_nettype wire

// ==== verification/ula_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ula_defines.svh"

module ulaTb
  import ula_bus_pkg::*;
  import ula_video_pkg::*;
();

  localparam int RESET_CYCLES   = 4;
  localparam int CPU_CYCLES     = 200;        // Random CPU accesses
  localparam int LINE_CLKS      = `H_TOTAL * `SEQ_STATES;
  localparam int HSYNC_LOW_CLKS = (`H_SYNC_END - `H_SYNC_START + 1) * `SEQ_STATES;
  localparam int ACTIVE_CLKS    = `H_ACTIVE_END * `SEQ_STATES;  // Columns 1 to 40
  localparam int LINES_60       = 261;
  localparam int LINES_50       = 313;
  localparam int SKIP_CLKS      = 2 * `SEQ_STATES;  // First two character times
  localparam int PIX_PER_CYCLE  = 6;          // Pixels per character
  localparam int LATCH_PER_CYCLE = 3;         // One per memory phase
  localparam int TIMEOUT_CYCLES = 2_500_000;  // About five frames plus margin

  logic     CLK_24;
  logic     RESET_INT;
  logic     RW;
  logic     MAPn;
  dataByteT DB;
  cpuAddrT  ADDR;
  dataByteT wrData;    // CPU write data
  logic     PHI2, PHI2_EN;
  logic     CSIOn, CSROMn, CSRAMn;
  cpuAddrT  SRAM_AD;
  logic     SRAM_OE, SRAM_CE, SRAM_WE, LATCH_SRAM;
  logic     R, G, B;
  logic     SYNC, HSYNC, VSYNC;
  logic     CLK_PIX, HBLANK, VBLANK;

  dataByteT mem [0:65535];  // Static RAM model
  int       cycle = 0;
  int       errCount = 0;
  int       weCount = 0;
  int       pixCount = -1;  // Negative until the first PHI2_EN
  int       latchCount = 0;
  logic     expWe = 1'b0;
  logic     prevPhi2 = 1'b0;
  chipSelT  expSel;

  ula_top UUT (
    .CLK_24, .RESET_INT, .RW, .MAPn, .DB, .ADDR, .PHI2, .PHI2_EN,
    .CSIOn, .CSROMn, .CSRAMn, .SRAM_AD, .SRAM_OE, .SRAM_CE, .SRAM_WE,
    .LATCH_SRAM, .R, .G, .B, .SYNC, .HSYNC, .VSYNC, .CLK_PIX, .HBLANK, .VBLANK
  );

  initial CLK_24 = 1'b0;
  always #5 CLK_24 = ~CLK_24;  // 10 ns period

  // CPU drives the bus during its writes, memory otherwise
  assign DB = (PHI2 && !RW) ? wrData : mem[SRAM_AD];

  always @(negedge CLK_24) begin
    if (SRAM_WE) mem[SRAM_AD] <= DB;
  end

  ////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////
  task automatic stopWithFailure();
    errCount++;
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic reportMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
    stopWithFailure();
  endtask

  task automatic reportFailure(input string what);
    $display("%s at %0t", what, $time);
    stopWithFailure();
  endtask

  // Decode rule: page 3 is I/O, ROM from 0xC000 with MAPn high, RAM otherwise
  function automatic chipSelT expectedSelects(input cpuAddrT a, input logic mapN);
    chipSelT s;
    logic    io;
    logic    rom;
    io     = (a[15:8] == 8'h03);
    rom    = !io && (a >= 16'hC000) && mapN;
    s.ioN  = !io;
    s.romN = !rom;
    s.ramN = io || rom;
    return s;
  endfunction

  task automatic fillMemory(input dataByteT value);
    for (int i = 0; i < 65536; i++) begin
      mem[i] = value;
    end
  endtask

  always @(posedge CLK_24) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      reportFailure("Timeout, the tests did not finish within the cycle limit");
    end
  end

  ////////////////////////////////////////
  // CPU bus monitor
  ////////////////////////////////////////
  always @(negedge CLK_24) begin
    assert (UUT.uAssert.failCount == 0)
      else reportFailure("A bound assertion in ulaAssert failed");
    if (!RESET_INT) begin
      expSel = expectedSelects(ADDR, MAPn);
      // RAM enabled for both video fetches and CPU RAM accesses
      assert (SRAM_CE == (!PHI2 || !expSel.ramN))
        else reportMismatch("SRAM_CE", SRAM_CE, !PHI2 || !expSel.ramN);
      // Outputs driven on video fetches and CPU reads
      assert (SRAM_OE == (!PHI2 || RW))
        else reportMismatch("SRAM_OE", SRAM_OE, !PHI2 || RW);
      if (VSYNC) begin  // Composite follows HSYNC outside vertical sync
        assert (SYNC == HSYNC) else reportMismatch("SYNC", SYNC, HSYNC);
      end
      if (PHI2) begin
        if (!prevPhi2) begin  // Clock after PHI2_EN
          assert (SRAM_AD == ADDR) else reportMismatch("SRAM_AD", SRAM_AD, ADDR);
        end
        assert (CSIOn == expSel.ioN) else reportMismatch("CSIOn", CSIOn, expSel.ioN);
        assert (CSROMn == expSel.romN) else reportMismatch("CSROMn", CSROMn, expSel.romN);
        assert (CSRAMn == expSel.ramN) else reportMismatch("CSRAMn", CSRAMn, expSel.ramN);
        expWe = !expSel.ramN && !RW;
        if (SRAM_WE) weCount++;
      end else if (prevPhi2) begin  // Phase 3 just ended
        assert (weCount == int'(expWe))
          else reportMismatch("SRAM_WE pulses", weCount, expWe);
        weCount = 0;
      end
      prevPhi2 = PHI2;
    end
  end

  // Pixel and latch strobes over one CPU cycle
  always @(negedge CLK_24) begin
    if (RESET_INT) begin
      pixCount   = -1;
      latchCount = 0;
    end else begin
      if (PHI2_EN) begin
        if (pixCount >= 0) begin
          assert (pixCount == PIX_PER_CYCLE)
            else reportMismatch("CLK_PIX pulses", pixCount, PIX_PER_CYCLE);
          assert (latchCount == LATCH_PER_CYCLE)
            else reportMismatch("LATCH_SRAM pulses", latchCount, LATCH_PER_CYCLE);
        end
        pixCount   = 0;
        latchCount = 0;
      end
      if (pixCount >= 0) begin
        pixCount   += CLK_PIX;
        latchCount += !LATCH_SRAM;  // Active low
      end
    end
  end

  // Waits for HSYNC to reach level, returns the cycle count
  task automatic waitHsync(input logic level, output int t);
    logic prev;
    @(negedge CLK_24);
    do begin
      prev = HSYNC;
      @(negedge CLK_24);
    end while (!(prev != level && HSYNC == level));
    t = cycle;
  endtask

  task automatic checkLineTiming();
    int tFall;
    int tRise;
    int tNext;
    waitHsync(1'b0, tFall);
    waitHsync(1'b1, tRise);
    waitHsync(1'b0, tNext);
    assert (tRise - tFall == HSYNC_LOW_CLKS)
      else reportMismatch("HSYNC low clocks", tRise - tFall, HSYNC_LOW_CLKS);
    assert (tNext - tFall == LINE_CLKS)
      else reportMismatch("HSYNC period", tNext - tFall, LINE_CLKS);
  endtask

  // Runs to the next VSYNC fall
  // An expLines of 0 skips the frame checks
  task automatic measureFrame(input int expLines, input logic checkRgb, input rgbT expRgb);
    int   t0;
    int   activeClks;
    int   activeLines;
    logic synced;       // Blanking seen, so runs are whole lines
    logic prev;
    t0 = cycle;
    activeClks = 0;
    activeLines = 0;
    synced = 1'b0;
    do begin
      prev = VSYNC;
      @(negedge CLK_24);
      if (HBLANK || VBLANK) begin
        if (synced && activeClks > 0) begin  // End of a visible line
          activeLines++;
          assert (activeClks == ACTIVE_CLKS)
            else reportMismatch("Active clocks per line", activeClks, ACTIVE_CLKS);
        end
        synced = 1'b1;
        activeClks = 0;
      end else if (synced) begin
        activeClks++;
      end
      if (checkRgb && activeClks > SKIP_CLKS) begin
        assert ({B, G, R} == expRgb) else reportMismatch("RGB", {B, G, R}, expRgb);
      end
    end while (!(prev && !VSYNC));
    if (expLines > 0) begin
      assert (cycle - t0 == expLines * LINE_CLKS)
        else reportMismatch("VSYNC period", cycle - t0, expLines * LINE_CLKS);
      assert (activeLines == `V_BLANK_START)
        else reportMismatch("Active lines", activeLines, `V_BLANK_START);
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  initial begin
    void'($urandom(32'h5a24));
    RESET_INT = 1'b1;
    RW = 1'b1;
    MAPn = 1'b1;
    ADDR = '0;
    wrData = '0;
    fillMemory(8'h7F);
    repeat (RESET_CYCLES) @(posedge CLK_24);
    #1;
    RESET_INT = 1'b0;

    // Random CPU accesses, one per CPU cycle
    repeat (CPU_CYCLES) begin
      @(negedge PHI2);
      #1;
      ADDR = cpuAddrT'($urandom);
      if ($urandom_range(7) == 0) ADDR[15:8] = 8'h03;  // Hit the I/O page now and then
      MAPn = logic'($urandom_range(1));
      RW = logic'($urandom_range(1));
      wrData = dataByteT'($urandom) | 8'h40;  // Bit 6 set, never an attribute
    end
    @(negedge PHI2);
    #1;
    RW = 1'b1;  // Reads only from here on

    checkLineTiming();

    // All ones pattern, white ink after reset
    fillMemory(8'h7F);
    measureFrame(0, 1'b0, 3'b000);
    measureFrame(LINES_60, 1'b1, 3'b111);

    fillMemory(8'hFF);  // Inverse video
    measureFrame(LINES_60, 1'b1, 3'b000);

    fillMemory(8'h1A);  // Mode attribute, 50 Hz
    measureFrame(0, 1'b1, 3'b000);
    measureFrame(LINES_50, 1'b1, 3'b000);

    if (errCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+rtl
rtl/ula_bus_pkg.sv
rtl/ula_video_pkg.sv
rtl/ula_sequencer.sv
rtl/ula_video_timing.sv
rtl/ula_attribute_decoder.sv
rtl/ula_memory_controller.sv
rtl/ula_top.sv
verification/ula_assert.sv
verification/ula_tb.sv

// ==== Bender.yml ====
package:
  name: oric_ula

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ula_bus_pkg.sv
      - rtl/ula_video_pkg.sv
      - rtl/ula_sequencer.sv
      - rtl/ula_video_timing.sv
      - rtl/ula_attribute_decoder.sv
      - rtl/ula_memory_controller.sv
      - rtl/ula_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verification/ula_assert.sv
      - verification/ula_tb.sv
